//--- muldiv_op_pkg.sv
package muldiv_op_pkg;

  typedef enum logic [3:0] {
    OP_NONE   = 4'd0,
    OP_MUL    = 4'd1,
    OP_MULH   = 4'd2,
    OP_MULHSU = 4'd3,
    OP_MULHU  = 4'd4,
    OP_DIV    = 4'd5,
    OP_DIVU   = 4'd6,
    OP_REM    = 4'd7,
    OP_REMU   = 4'd8
  } muldiv_op_t;

  function automatic logic is_mul_op(input muldiv_op_t op);
    return op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
  endfunction

  function automatic logic is_div_op(input muldiv_op_t op);
    return op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  endfunction

  // Upper half of the product is returned
  function automatic logic is_mul_high(input muldiv_op_t op);
    return op inside {OP_MULH, OP_MULHSU, OP_MULHU};
  endfunction

  function automatic logic is_rem_op(input muldiv_op_t op);
    return op inside {OP_REM, OP_REMU};
  endfunction

  function automatic logic is_signed_rs1(input muldiv_op_t op);
    return op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_DIV, OP_REM};
  endfunction

  function automatic logic is_signed_rs2(input muldiv_op_t op);
    return op inside {OP_MUL, OP_MULH, OP_DIV, OP_REM};
  endfunction

endpackage

//--- muldiv_tag_pkg.sv
package muldiv_tag_pkg;

  localparam int RD_TAG_W  = 6;
  localparam int BR_MASK_W = 4;
  localparam int BR_TAG_W  = $clog2(BR_MASK_W);

  // Destination tag, travels with the result
  typedef logic [RD_TAG_W-1:0] rd_tag_t;

  // One bit per unresolved branch
  typedef logic [BR_MASK_W-1:0] br_mask_t;

  typedef logic [BR_TAG_W-1:0] br_tag_t;

  // An operation dies when the killed branch is one it depends on
  function automatic logic is_killed(
    input logic     kill_valid,
    input br_tag_t  kill_tag,
    input br_mask_t br_mask
  );
    return kill_valid & br_mask[kill_tag];
  endfunction

endpackage

//--- muldiv_mul_pipe.sv
`timescale 1ns/1ps

module muldiv_mul_pipe #(
  parameter int XLEN       = 32,
  parameter int MUL_UNROLL = 8
) (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  logic                      i_valid,
  input  muldiv_op_pkg::muldiv_op_t i_op,
  input  logic [XLEN-1:0]           i_rs1,
  input  logic [XLEN-1:0]           i_rs2,
  input  muldiv_tag_pkg::rd_tag_t   i_rd_tag,
  input  muldiv_tag_pkg::br_mask_t  i_br_mask,
  input  logic                      i_kill_valid,
  input  muldiv_tag_pkg::br_tag_t   i_kill_tag,
  output logic                      o_valid,
  output logic [XLEN-1:0]           o_res,
  output muldiv_tag_pkg::rd_tag_t   o_rd_tag,
  output logic                      o_busy_tail
);

  localparam int MUL_STEP = XLEN / MUL_UNROLL;

  typedef logic [XLEN:0]     oper_t;  // Operand plus extension bit
  typedef logic [2*XLEN-1:0] prod_t;

  oper_t w_op1;
  oper_t w_op2;

  // Stage sources, index 0 is the issue port
  logic                      w_valid  [MUL_STEP];
  muldiv_op_pkg::muldiv_op_t w_op     [MUL_STEP];
  muldiv_tag_pkg::rd_tag_t   w_rd_tag [MUL_STEP];
  muldiv_tag_pkg::br_mask_t  w_mask   [MUL_STEP];
  oper_t                     w_mplier [MUL_STEP];
  oper_t                     w_mcand  [MUL_STEP];
  prod_t                     w_acc    [MUL_STEP];

  logic                      r_valid  [1:MUL_STEP];
  muldiv_op_pkg::muldiv_op_t r_op     [1:MUL_STEP];
  muldiv_tag_pkg::rd_tag_t   r_rd_tag [1:MUL_STEP];
  muldiv_tag_pkg::br_mask_t  r_mask   [1:MUL_STEP];
  prod_t                     r_acc    [1:MUL_STEP];
  oper_t                     r_mplier [1:MUL_STEP-1];
  oper_t                     r_mcand  [1:MUL_STEP-1];

  assign w_op1 = muldiv_op_pkg::is_signed_rs1(i_op) ? {i_rs1[XLEN-1], i_rs1} : {1'b0, i_rs1};
  assign w_op2 = muldiv_op_pkg::is_signed_rs2(i_op) ? {i_rs2[XLEN-1], i_rs2} : {1'b0, i_rs2};

  // ================================================
  // Unrolled stages
  // ================================================

  for (genvar s = 0; s < MUL_STEP; s++) begin : g_stage
    logic [MUL_UNROLL:0] w_slice;
    prod_t               w_part;

    if (s == 0) begin : g_src_issue
      assign w_valid[s]  = i_valid;
      assign w_op[s]     = i_op;
      assign w_rd_tag[s] = i_rd_tag;
      assign w_mask[s]   = i_br_mask;
      assign w_mplier[s] = w_op1;
      assign w_mcand[s]  = w_op2;
      assign w_acc[s]    = '0;
    end else begin : g_src_reg
      assign w_valid[s]  = r_valid[s];
      assign w_op[s]     = r_op[s];
      assign w_rd_tag[s] = r_rd_tag[s];
      assign w_mask[s]   = r_mask[s];
      assign w_mplier[s] = r_mplier[s];
      assign w_mcand[s]  = r_mcand[s];
      assign w_acc[s]    = r_acc[s];
    end

    if (s == MUL_STEP - 1) begin : g_top_slice
      assign w_slice = {w_mcand[s][XLEN], w_mcand[s][s*MUL_UNROLL +: MUL_UNROLL]};  // Sign weight
    end else begin : g_low_slice
      assign w_slice = {1'b0, w_mcand[s][s*MUL_UNROLL +: MUL_UNROLL]};
    end

    assign w_part = {{(XLEN-1){w_mplier[s][XLEN]}}, w_mplier[s]}
                  * {{(2*XLEN-MUL_UNROLL-1){w_slice[MUL_UNROLL]}}, w_slice};

    always_ff @(posedge i_clk or negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_valid[s+1] <= 1'b0;
      end else begin
        r_valid[s+1] <= w_valid[s] &
                        ~muldiv_tag_pkg::is_killed(i_kill_valid, i_kill_tag, w_mask[s]);
      end
    end

    always_ff @(posedge i_clk) begin
      r_acc[s+1]    <= w_acc[s] + (w_part << (s * MUL_UNROLL));
      r_op[s+1]     <= w_op[s];
      r_rd_tag[s+1] <= w_rd_tag[s];
      r_mask[s+1]   <= w_mask[s];
    end

    if (s < MUL_STEP - 1) begin : g_pass_oper
      always_ff @(posedge i_clk) begin
        r_mplier[s+1] <= w_mplier[s];
        r_mcand[s+1]  <= w_mcand[s];
      end
    end
  end

  // ================================================
  // Result
  // ================================================

  assign o_valid = r_valid[MUL_STEP] &
                   ~muldiv_tag_pkg::is_killed(i_kill_valid, i_kill_tag, r_mask[MUL_STEP]);

  assign o_res = muldiv_op_pkg::is_mul_high(r_op[MUL_STEP]) ?
                 r_acc[MUL_STEP][2*XLEN-1:XLEN] : r_acc[MUL_STEP][XLEN-1:0];

  assign o_rd_tag = r_rd_tag[MUL_STEP];

  assign o_busy_tail = r_valid[MUL_STEP-1] | r_valid[MUL_STEP];  // Last two stages

endmodule

//--- muldiv_div_unit.sv
`timescale 1ns/1ps

module muldiv_div_unit #(
  parameter int XLEN = 32
) (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  logic                      i_valid,
  input  muldiv_op_pkg::muldiv_op_t i_op,
  input  logic [XLEN-1:0]           i_rs1,
  input  logic [XLEN-1:0]           i_rs2,
  input  muldiv_tag_pkg::rd_tag_t   i_rd_tag,
  input  muldiv_tag_pkg::br_mask_t  i_br_mask,
  input  logic                      i_kill_valid,
  input  muldiv_tag_pkg::br_tag_t   i_kill_tag,
  input  logic                      i_resp_ready,
  output logic                      o_ready,
  output logic                      o_valid,
  output logic [XLEN-1:0]           o_res,
  output muldiv_tag_pkg::rd_tag_t   o_rd_tag
);

  localparam int CNT_W = $clog2(XLEN);
  localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

  typedef enum logic [2:0] {
    IDLE,
    SPECIAL,
    RUN,
    FIX,
    DONE
  } div_state_t;

  div_state_t r_state;
  div_state_t w_state_next;

  muldiv_op_pkg::muldiv_op_t r_op;
  muldiv_tag_pkg::rd_tag_t   r_rd_tag;
  muldiv_tag_pkg::br_mask_t  r_br_mask;

  logic [XLEN-1:0]  r_quot;     // Dividend shifts out, quotient shifts in
  logic [XLEN-1:0]  r_rem;
  logic [XLEN-1:0]  r_divisor;
  logic [XLEN-1:0]  r_res;
  logic [CNT_W-1:0] r_count;
  logic             r_neg_q;
  logic             r_neg_r;
  logic             r_div_zero;

  logic            w_signed;
  logic            w_rs1_neg;
  logic            w_rs2_neg;
  logic [XLEN-1:0] w_abs_rs1;
  logic [XLEN-1:0] w_abs_rs2;
  logic            w_div_zero;
  logic            w_overflow;
  logic            w_special;
  logic            w_accept;
  logic            w_kill;
  logic [XLEN:0]   w_rem_shift;
  logic [XLEN:0]   w_diff;

  // ================================================
  // Issue decode
  // ================================================

  assign w_signed   = muldiv_op_pkg::is_signed_rs1(i_op);
  assign w_rs1_neg  = w_signed & i_rs1[XLEN-1];
  assign w_rs2_neg  = w_signed & i_rs2[XLEN-1];
  assign w_abs_rs1  = w_rs1_neg ? -i_rs1 : i_rs1;
  assign w_abs_rs2  = w_rs2_neg ? -i_rs2 : i_rs2;
  assign w_div_zero = (i_rs2 == '0);
  assign w_overflow = w_signed & (i_rs1 == MOST_NEG) & (&i_rs2);
  assign w_special  = w_div_zero | w_overflow;

  assign w_accept = i_valid & (r_state == IDLE) &
                    ~muldiv_tag_pkg::is_killed(i_kill_valid, i_kill_tag, i_br_mask);
  assign w_kill   = muldiv_tag_pkg::is_killed(i_kill_valid, i_kill_tag, r_br_mask);

  // One restoring step
  assign w_rem_shift = {r_rem, r_quot[XLEN-1]};
  assign w_diff      = w_rem_shift - {1'b0, r_divisor};

  // ================================================
  // FSM
  // ================================================

  always_comb begin
    w_state_next = r_state;
    case (r_state)
      IDLE:    if (w_accept) w_state_next = w_special ? SPECIAL : RUN;
      SPECIAL: w_state_next = FIX;
      RUN:     if (r_count == '0) w_state_next = FIX;
      FIX:     w_state_next = DONE;
      DONE:    if (i_resp_ready) w_state_next = IDLE;
      default: w_state_next = IDLE;
    endcase
    if ((r_state != IDLE) && w_kill) begin
      w_state_next = IDLE;  // Dropped without a result
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= IDLE;
    end else begin
      r_state <= w_state_next;
    end
  end

  always_ff @(posedge i_clk) begin
    case (r_state)
      IDLE: begin
        if (w_accept) begin
          r_op       <= i_op;
          r_rd_tag   <= i_rd_tag;
          r_br_mask  <= i_br_mask;
          r_quot     <= w_special ? i_rs1 : w_abs_rs1;
          r_rem      <= '0;
          r_divisor  <= w_abs_rs2;
          r_count    <= CNT_W'(XLEN - 1);
          r_div_zero <= w_div_zero;
          r_neg_q    <= ~w_special & (w_rs1_neg ^ w_rs2_neg);
          r_neg_r    <= ~w_special & w_rs1_neg;  // Remainder takes the dividend sign
        end
      end
      SPECIAL: begin
        if (r_div_zero) begin
          r_quot <= '1;
          r_rem  <= r_quot;
        end
      end
      RUN: begin
        r_quot  <= {r_quot[XLEN-2:0], ~w_diff[XLEN]};
        r_rem   <= w_diff[XLEN] ? w_rem_shift[XLEN-1:0] : w_diff[XLEN-1:0];
        r_count <= r_count - 1'b1;
      end
      FIX: begin
        if (muldiv_op_pkg::is_rem_op(r_op)) begin
          r_res <= r_neg_r ? -r_rem : r_rem;
        end else begin
          r_res <= r_neg_q ? -r_quot : r_quot;
        end
      end
      default: ;
    endcase
  end

  assign o_ready  = (r_state == IDLE);
  assign o_valid  = (r_state == DONE) & ~w_kill;
  assign o_res    = r_res;
  assign o_rd_tag = r_rd_tag;

endmodule

//--- muldiv_pipe.sv
`timescale 1ns/1ps

module muldiv_pipe #(
  parameter int XLEN       = 32,
  parameter int MUL_UNROLL = 8
) (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  logic                      i_valid,
  input  muldiv_op_pkg::muldiv_op_t i_op,
  input  logic [XLEN-1:0]           i_rs1,
  input  logic [XLEN-1:0]           i_rs2,
  input  muldiv_tag_pkg::rd_tag_t   i_rd_tag,
  input  muldiv_tag_pkg::br_mask_t  i_br_mask,
  input  logic                      i_kill_valid,
  input  muldiv_tag_pkg::br_tag_t   i_kill_tag,
  output logic                      o_stall,
  output logic                      o_valid,
  output logic [XLEN-1:0]           o_res,
  output muldiv_tag_pkg::rd_tag_t   o_rd_tag
);

  logic                    w_mul_valid;
  logic [XLEN-1:0]         w_mul_res;
  muldiv_tag_pkg::rd_tag_t w_mul_rd_tag;
  logic                    w_mul_busy_tail;

  logic                    w_div_ready;
  logic                    w_div_valid;
  logic [XLEN-1:0]         w_div_res;
  muldiv_tag_pkg::rd_tag_t w_div_rd_tag;

  // ================================================
  // Issue split
  // ================================================

  muldiv_mul_pipe #(
    .XLEN       (XLEN),
    .MUL_UNROLL (MUL_UNROLL)
  ) u_mul (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_valid      (i_valid & muldiv_op_pkg::is_mul_op(i_op)),
    .i_op         (i_op),
    .i_rs1        (i_rs1),
    .i_rs2        (i_rs2),
    .i_rd_tag     (i_rd_tag),
    .i_br_mask    (i_br_mask),
    .i_kill_valid (i_kill_valid),
    .i_kill_tag   (i_kill_tag),
    .o_valid      (w_mul_valid),
    .o_res        (w_mul_res),
    .o_rd_tag     (w_mul_rd_tag),
    .o_busy_tail  (w_mul_busy_tail)
  );

  muldiv_div_unit #(
    .XLEN (XLEN)
  ) u_div (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_valid      (i_valid & muldiv_op_pkg::is_div_op(i_op)),
    .i_op         (i_op),
    .i_rs1        (i_rs1),
    .i_rs2        (i_rs2),
    .i_rd_tag     (i_rd_tag),
    .i_br_mask    (i_br_mask),
    .i_kill_valid (i_kill_valid),
    .i_kill_tag   (i_kill_tag),
    .i_resp_ready (~w_mul_valid),  // Multiplier wins the write-back
    .o_ready      (w_div_ready),
    .o_valid      (w_div_valid),
    .o_res        (w_div_res),
    .o_rd_tag     (w_div_rd_tag)
  );

  // Divider busy, or multiplies about to leave the pipe
  assign o_stall = ~w_div_ready | w_mul_busy_tail;

  // ================================================
  // Write-back merge
  // ================================================

  assign o_valid  = w_mul_valid | w_div_valid;
  assign o_res    = w_mul_valid ? w_mul_res : w_div_res;
  assign o_rd_tag = w_mul_valid ? w_mul_rd_tag : w_div_rd_tag;

endmodule

//--- tb_muldiv_pipe.sv
`timescale 1ns/1ps

module tb_muldiv_pipe;

  localparam int N_OPS = 260;
  localparam logic [31:0] MIN_VAL = 32'h8000_0000;

  typedef struct {
    muldiv_tag_pkg::rd_tag_t  tag;
    logic [31:0]              res;
    bit                       is_mul;
    bit                       is_div;
    muldiv_tag_pkg::br_mask_t mask;
    int                       cyc;  // Cycle that holds the issue
  } exp_t;

  logic                      i_clk;
  logic                      i_reset_n;
  logic                      i_valid;
  muldiv_op_pkg::muldiv_op_t i_op;
  logic [31:0]               i_rs1;
  logic [31:0]               i_rs2;
  muldiv_tag_pkg::rd_tag_t   i_rd_tag;
  muldiv_tag_pkg::br_mask_t  i_br_mask;
  logic                      i_kill_valid;
  muldiv_tag_pkg::br_tag_t   i_kill_tag;
  logic                      o_stall;
  logic                      o_valid;
  logic [31:0]               o_res;
  muldiv_tag_pkg::rd_tag_t   o_rd_tag;

  exp_t        exp_q[$];
  logic [31:0] lfsr = 32'h11c3;
  int          cyc = 0;
  int          errors = 0;
  bit          mul_h[3];  // Multiplies driven one, two, three edges back
  bit          div_h;
  bit          stall_neg;
  bit          any_issued = 0;
  bit          chk_valid = 0, tag_found = 1, value_ok = 1, order_ok = 1, lat_ok = 1;
  bit          stall_ok = 1;
  logic [31:0] got_res, exp_res;
  int          got_tag, next_tag = 0;

  muldiv_pipe i_dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  always @(posedge i_clk) cyc <= cyc + 1;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] rand_operand();
    case (rand_bits(3))
      3'd0:    return '0;
      3'd1:    return '1;
      3'd2:    return MIN_VAL;
      default: return rand_bits(32);
    endcase
  endfunction

  // RISC-V M extension rules
  function automatic logic [31:0] ref_result(input muldiv_op_pkg::muldiv_op_t op,
                                             input logic [31:0] a, input logic [31:0] b);
    logic [63:0] ea, eb, p;
    bit          sgn;
    ea  = (op == muldiv_op_pkg::OP_MULHU) ? {32'b0, a} : {{32{a[31]}}, a};
    eb  = (op == muldiv_op_pkg::OP_MULHU || op == muldiv_op_pkg::OP_MULHSU) ?
          {32'b0, b} : {{32{b[31]}}, b};
    p   = ea * eb;
    sgn = (op == muldiv_op_pkg::OP_DIV || op == muldiv_op_pkg::OP_REM);
    case (op)
      muldiv_op_pkg::OP_MUL: return p[31:0];
      muldiv_op_pkg::OP_MULH, muldiv_op_pkg::OP_MULHSU, muldiv_op_pkg::OP_MULHU:
        return p[63:32];
      default: begin
        if (b == 0) begin
          return (op == muldiv_op_pkg::OP_DIV || op == muldiv_op_pkg::OP_DIVU) ? '1 : a;
        end else if (sgn && a == MIN_VAL && b == '1) begin
          return (op == muldiv_op_pkg::OP_DIV) ? a : '0;
        end else if (op == muldiv_op_pkg::OP_DIV) begin
          return $signed(a) / $signed(b);
        end else if (op == muldiv_op_pkg::OP_REM) begin
          return $signed(a) % $signed(b);
        end else if (op == muldiv_op_pkg::OP_DIVU) begin
          return a / b;
        end
        return a % b;
      end
    endcase
  endfunction

  task automatic report_fail(input string msg);
    errors++;
    $display("Fail %0t: %s", $time, msg);
    $display("ERRORS FOUND");
    $fatal(1, "testbench check failed");
  endtask

  task automatic push_hist(input bit is_mul, input bit is_div);
    mul_h[2] = mul_h[1];
    mul_h[1] = mul_h[0];
    mul_h[0] = is_mul;
    div_h    = is_div;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      push_hist(0, 0);
      @(posedge i_clk);
    end
  endtask

  // Issue may go out only if o_stall will be low at the sampling edge
  task automatic issue_op(input muldiv_op_pkg::muldiv_op_t op, input logic [31:0] a,
                          input logic [31:0] b, input muldiv_tag_pkg::br_mask_t mask,
                          input bit kv, input muldiv_tag_pkg::br_tag_t kt);
    while (stall_neg || div_h || mul_h[2]) idle(1);
    i_valid      <= 1'b1;
    i_op         <= op;
    i_rs1        <= a;
    i_rs2        <= b;
    i_rd_tag     <= muldiv_tag_pkg::rd_tag_t'(next_tag);
    i_br_mask    <= mask;
    i_kill_valid <= kv;
    i_kill_tag   <= kt;
    next_tag     = (next_tag + 1) % 64;
    push_hist(muldiv_op_pkg::is_mul_op(op), muldiv_op_pkg::is_div_op(op));
    @(posedge i_clk);
    i_valid      <= 1'b0;
    i_kill_valid <= 1'b0;
  endtask

  task automatic send_kill(input muldiv_tag_pkg::br_tag_t kt);
    i_kill_valid <= 1'b1;
    i_kill_tag   <= kt;
    push_hist(0, 0);
    @(posedge i_clk);
    i_kill_valid <= 1'b0;
  endtask

  // ==================================================
  // Scoreboard, runs where outputs are stable
  // ==================================================

  always @(negedge i_clk) begin : monitor
    int   idx;
    int   first_mul;
    bit   div_live;
    exp_t e;
    chk_valid = 0;
    tag_found = 1;
    value_ok  = 1;
    order_ok  = 1;
    lat_ok    = 1;
    stall_neg = o_stall;
    if (i_reset_n) begin
      div_live = 0;
      foreach (exp_q[k]) if (exp_q[k].is_div) div_live = 1;
      stall_ok = !div_live || o_stall;
      if (o_valid) begin
        chk_valid = 1;
        idx       = -1;
        first_mul = -1;
        got_tag   = o_rd_tag;
        got_res   = o_res;
        foreach (exp_q[k]) begin
          if (idx < 0 && exp_q[k].tag == o_rd_tag) idx = k;
          if (first_mul < 0 && exp_q[k].is_mul) first_mul = k;
        end
        tag_found = (idx >= 0);
        if (tag_found) begin
          exp_res  = exp_q[idx].res;
          value_ok = (o_res == exp_q[idx].res);
          order_ok = !exp_q[idx].is_mul || idx == first_mul;
          lat_ok   = !exp_q[idx].is_mul || (cyc - exp_q[idx].cyc == 4);
          exp_q.delete(idx);
        end
      end
      if (i_kill_valid) begin
        for (int k = exp_q.size() - 1; k >= 0; k--) begin
          if (exp_q[k].mask[i_kill_tag]) exp_q.delete(k);
        end
      end
      if (i_valid && !(i_kill_valid && i_br_mask[i_kill_tag])) begin
        any_issued = 1;
        e.tag    = i_rd_tag;
        e.res    = ref_result(i_op, i_rs1, i_rs2);
        e.is_mul = muldiv_op_pkg::is_mul_op(i_op);
        e.is_div = muldiv_op_pkg::is_div_op(i_op);
        e.mask   = i_br_mask;
        e.cyc    = cyc;
        exp_q.push_back(e);
      end
    end
  end

  a_tag: assert property (@(posedge i_clk) disable iff (!i_reset_n) chk_valid |-> tag_found)
    else report_fail($sformatf("tag %0d was not expected", got_tag));
  a_value: assert property (@(posedge i_clk) disable iff (!i_reset_n) chk_valid |-> value_ok)
    else report_fail($sformatf("tag %0d got %h expected %h", got_tag, got_res, exp_res));
  a_order: assert property (@(posedge i_clk) disable iff (!i_reset_n) chk_valid |-> order_ok)
    else report_fail($sformatf("multiply tag %0d out of order", got_tag));
  a_latency: assert property (@(posedge i_clk) disable iff (!i_reset_n) chk_valid |-> lat_ok)
    else report_fail($sformatf("multiply tag %0d not 4 cycles after issue", got_tag));
  a_div_stall: assert property (@(posedge i_clk) disable iff (!i_reset_n) stall_ok)
    else report_fail("o_stall low while a division is in flight");
  a_issue: assert property (@(posedge i_clk) disable iff (!i_reset_n) !(i_valid && o_stall))
    else report_fail("operation issued while o_stall was high");
  a_quiet: assert property (@(posedge i_clk) disable iff (!i_reset_n)
                            !any_issued |-> !o_valid && !o_stall)
    else report_fail("output activity before the first issue");

  initial begin : watchdog
    #((N_OPS * 40 + 16 + 20) * 8);
    $display("Timeout: results still outstanding after the expected run time");
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

  // ==================================================
  // Stimulus
  // ==================================================

  initial begin : stimulus
    logic [31:0] pa [6] = '{MIN_VAL, '1, MIN_VAL, 32'h1234_5678, '0, 32'hffff_fff9};
    logic [31:0] pb [6] = '{MIN_VAL, '1, '1, 32'h9abc_def0, 32'h7fff_ffff, 32'd2};
    logic [31:0] da [6] = '{32'd55, MIN_VAL, 32'hffff_fff9, 32'd7, 32'd100, MIN_VAL};
    logic [31:0] db [6] = '{'0, '1, 32'd2, 32'hffff_fffe, 32'd7, 32'd1};
    muldiv_op_pkg::muldiv_op_t op;
    i_reset_n = 1'b0;
    i_valid = 1'b0;
    i_op = muldiv_op_pkg::OP_NONE;
    i_rs1 = '0;
    i_rs2 = '0;
    i_rd_tag = '0;
    i_br_mask = '0;
    i_kill_valid = 1'b0;
    i_kill_tag = '0;
    repeat (16) @(posedge i_clk);
    i_reset_n <= 1'b1;
    idle(6);
    for (int o = 1; o <= 4; o++) begin
      for (int i = 0; i < 6; i++) issue_op(muldiv_op_pkg::muldiv_op_t'(o), pa[i], pb[i], 0, 0, 0);
    end
    for (int o = 5; o <= 8; o++) begin
      for (int i = 0; i < 6; i++) issue_op(muldiv_op_pkg::muldiv_op_t'(o), da[i], db[i], 0, 0, 0);
    end
    // Quick division lands on top of multiplies in flight
    issue_op(muldiv_op_pkg::OP_MUL, 32'd3, 32'd5, 0, 0, 0);
    issue_op(muldiv_op_pkg::OP_MULHU, '1, '1, 0, 0, 0);
    issue_op(muldiv_op_pkg::OP_DIVU, 32'd9, '0, 0, 0, 0);
    issue_op(muldiv_op_pkg::OP_MUL, 32'd6, 32'd7, 0, 0, 0);
    // Kills at issue, mid-pipeline and inside the divider
    issue_op(muldiv_op_pkg::OP_MUL, 32'd11, 32'd13, 4'b0010, 0, 0);
    issue_op(muldiv_op_pkg::OP_MULH, MIN_VAL, 32'd3, 4'b0001, 0, 0);
    send_kill(2'd1);
    issue_op(muldiv_op_pkg::OP_MUL, 32'd17, 32'd19, 4'b0100, 1, 2'd2);
    issue_op(muldiv_op_pkg::OP_REM, 32'd1000, 32'd3, 4'b1000, 0, 0);
    idle(7);
    send_kill(2'd3);
    issue_op(muldiv_op_pkg::OP_DIV, 32'd1000, 32'd3, 4'b0001, 0, 0);
    for (int n = 0; n < 200; n++) begin
      op = muldiv_op_pkg::muldiv_op_t'(rand_bits(3) + 1);
      issue_op(op, rand_operand(), rand_operand(), rand_bits(4), rand_bits(3) == 0, rand_bits(2));
      if (rand_bits(2) == 0) idle(1);
    end
    while (exp_q.size() != 0) idle(1);
    idle(10);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- muldiv_pipe.f
muldiv_op_pkg.sv
muldiv_tag_pkg.sv
muldiv_mul_pipe.sv
muldiv_div_unit.sv
muldiv_pipe.sv
tb_muldiv_pipe.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the muldiv_pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f muldiv_pipe.f \
  --top-module tb_muldiv_pipe -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^NO ERRORS$"; then
  exit 0
else
  exit 1
fi
